/* verification/issue_testdata.txt */
# COMMIT we0 addr0 data0 we1 addr1 data1
# ISSUE fu op rs1 rs2 rd uimm uzimm upc exv imm pc creg cfu f1v f1 f2v f2 flu lsu flush cwe caddr ack valid opa opb
COMMIT 1 01 1111 1 02 2222
COMMIT 1 00 dead 1 03 3333
ISSUE 1 0 01 02 04 0 0 0 0 0 0 00 0 0 0 0 0 1 1 0 0 00 1 10 1111 2222
ISSUE 1 0 00 03 04 0 0 0 0 0 0 00 0 0 0 0 0 1 1 0 0 00 1 10 0 3333
ISSUE 1 0 01 02 04 0 0 0 0 0 0 01 1 1 aaaa 0 0 1 1 0 0 00 1 10 aaaa 2222
ISSUE 1 0 01 02 04 0 0 0 0 0 0 01 6 1 aaaa 0 0 1 1 0 0 00 0 00 0 0
ISSUE 1 0 01 02 04 0 0 0 0 0 0 02 1 0 0 0 0 1 1 0 0 00 0 00 0 0
ISSUE 1 0 01 02 05 0 0 0 0 0 0 05 1 0 0 0 0 1 1 0 0 00 0 00 0 0
ISSUE 1 0 01 02 05 0 0 0 0 0 0 05 1 0 0 0 0 1 1 0 1 05 1 10 1111 2222
ISSUE 3 a 01 02 06 1 0 0 0 10 0 00 0 0 0 0 0 1 0 0 0 00 0 00 0 0
ISSUE 3 a 01 02 06 1 0 0 0 10 0 00 0 0 0 0 0 1 1 0 0 00 1 04 1111 10
ISSUE 1 0 01 02 06 0 0 0 1 0 0 01 6 0 0 0 0 1 1 0 0 00 1 00 0 0
ISSUE 0 0 01 02 06 0 0 0 0 0 0 00 0 0 0 0 0 0 0 0 0 00 1 00 0 0
ISSUE 5 c 01 02 07 0 0 0 0 0 0 00 0 0 0 0 0 1 1 0 0 00 1 02 1111 2222
ISSUE 5 c 02 01 07 0 0 0 0 0 0 00 0 0 0 0 0 1 1 0 0 00 1 02 2222 1111
ISSUE 1 0 01 02 08 0 0 0 0 0 0 00 0 0 0 0 0 1 1 0 0 00 0 00 0 0
ISSUE 1 0 01 02 08 0 0 0 0 0 0 00 0 0 0 0 0 1 1 1 0 00 1 00 0 0
ISSUE 1 0 01 02 08 1 0 0 0 7f 0 00 0 0 0 0 0 1 1 0 0 00 1 10 1111 7f
ISSUE 4 b 01 02 00 1 0 0 0 7f 0 00 0 0 0 0 0 1 1 0 0 00 1 04 1111 2222
ISSUE 1 0 01 02 09 0 0 1 0 0 4000000000 00 0 0 0 0 0 1 1 0 0 00 1 10 ffffffc000000000 2222
ISSUE 1 0 1f 02 09 0 1 0 0 0 0 1f 6 0 0 0 0 1 1 0 0 00 1 10 1f 2222

/* vlog.f */
verilog/issue_pkg.sv
verilog/int_regfile.sv
verilog/operand_hazard.sv
verilog/operand_select.sv
verilog/issue_ctrl.sv
verilog/issue_read_operands.sv
verification/issue_assert.sv
verification/tb_issue_read_operands.sv

/* Makefile */
TOP := tb_issue_read_operands

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_issue_read_operands.sv */
module tb_issue_read_operands;

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------
    logic                    clk_i;
    logic                    rst_ni;
    logic                    flush_i;
    issue_pkg::issue_instr_t issue_instr;
    logic                    issue_valid;
    logic                    issue_ack;
    issue_pkg::reg_addr_t    rs1;
    issue_pkg::reg_addr_t    rs2;
    issue_pkg::fwd_port_t    fwd_rs1;
    issue_pkg::fwd_port_t    fwd_rs2;
    issue_pkg::clobber_t     clobber;
    issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit;
    logic                    flu_ready;
    logic                    lsu_ready;
    issue_pkg::fu_data_t     fu_data;
    issue_pkg::fu_valid_t    fu_valid;

    // fields of one data file line, all parsed as hex
    logic [63:0] v [26];
    string       line;
    int          fd;
    int          step_cnt;

    issue_read_operands i_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .issue_instr_i (issue_instr),
        .issue_valid_i (issue_valid),
        .issue_ack_o   (issue_ack),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .fwd_rs1_i     (fwd_rs1),
        .fwd_rs2_i     (fwd_rs2),
        .clobber_i     (clobber),
        .commit_i      (commit),
        .flu_ready_i   (flu_ready),
        .lsu_ready_i   (lsu_ready),
        .fu_data_o     (fu_data),
        .fu_valid_o    (fu_valid)
    );

    // 20 ns period
    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED t=%0t step %0d ack got %b exp %b",
                               $time, step_cnt, got, exp));
        end
    endtask

    task automatic check_unit(input issue_pkg::fu_valid_t got,
                              input issue_pkg::fu_valid_t exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED t=%0t step %0d unit valid got %b exp %b",
                               $time, step_cnt, got, exp));
        end
    endtask

    task automatic check_operand(input issue_pkg::xlen_t got, input issue_pkg::xlen_t exp,
                                 input string name);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED t=%0t step %0d %s got %h exp %h",
                               $time, step_cnt, name, got, exp));
        end
    endtask

    task automatic check_addr(input issue_pkg::reg_addr_t got,
                              input issue_pkg::reg_addr_t exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED t=%0t step %0d %s got %0d exp %0d",
                               $time, step_cnt, name, got, exp));
        end
    endtask

    task automatic check_fu(input issue_pkg::fu_t got, input issue_pkg::fu_t exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED t=%0t step %0d unit got %0d exp %0d",
                               $time, step_cnt, got, exp));
        end
    endtask

    task automatic check_op(input issue_pkg::fu_op_t got, input issue_pkg::fu_op_t exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED t=%0t step %0d operator got %0d exp %0d",
                               $time, step_cnt, got, exp));
        end
    endtask

    task automatic check_tag(input issue_pkg::trans_id_t got,
                             input issue_pkg::trans_id_t exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED t=%0t step %0d trans_id got %0d exp %0d",
                               $time, step_cnt, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    // quiet bus, every unit ready
    task automatic drive_idle();
        flush_i     = 1'b0;
        issue_instr = '0;
        issue_valid = 1'b0;
        fwd_rs1     = '0;
        fwd_rs2     = '0;
        clobber     = '0;
        commit      = '0;
        flu_ready   = 1'b1;
        lsu_ready   = 1'b1;
    endtask

    // both write ports for one cycle
    task automatic apply_commit();
        commit[0].we    = v[0][0];
        commit[0].waddr = v[1][4:0];
        commit[0].wdata = v[2];
        commit[1].we    = v[3][0];
        commit[1].waddr = v[4][4:0];
        commit[1].wdata = v[5];
        @(negedge clk_i);
        drive_idle();
    endtask

    task automatic apply_issue();
        issue_instr.fu       = issue_pkg::fu_t'(v[0][2:0]);
        issue_instr.op       = issue_pkg::fu_op_t'(v[1][3:0]);
        issue_instr.rs1      = v[2][4:0];
        issue_instr.rs2      = v[3][4:0];
        issue_instr.rd       = v[4][4:0];
        issue_instr.use_imm  = v[5][0];
        issue_instr.use_zimm = v[6][0];
        issue_instr.use_pc   = v[7][0];
        issue_instr.ex_valid = v[8][0];
        issue_instr.result   = v[9];
        issue_instr.pc       = v[10][38:0];
        // tag follows the step so a stale payload shows up
        issue_instr.trans_id = step_cnt[2:0];
        // a single clobber entry, unit zero means none
        clobber[v[11][4:0]]  = issue_pkg::fu_t'(v[12][2:0]);
        fwd_rs1.valid        = v[13][0];
        fwd_rs1.value        = v[14];
        fwd_rs2.valid        = v[15][0];
        fwd_rs2.value        = v[16];
        flu_ready            = v[17][0];
        lsu_ready            = v[18][0];
        flush_i              = v[19][0];
        commit[0].we         = v[20][0];
        commit[0].waddr      = v[21][4:0];
        issue_valid          = 1'b1;
        #2;
        // scoreboard lookup follows the sources of the instruction
        check_addr(rs1, v[2][4:0], "rs1_o");
        check_addr(rs2, v[3][4:0], "rs2_o");
        // ack belongs to the same cycle as the valid instruction
        check_ack(issue_ack, v[22][0]);
        // results are registered, sample them one cycle later
        @(negedge clk_i);
        check_unit(fu_valid, issue_pkg::fu_valid_t'(v[23][4:0]));
        if (v[23][4:0] != 5'd0) begin
            check_fu(fu_data.fu, issue_pkg::fu_t'(v[0][2:0]));
            check_op(fu_data.operator, issue_pkg::fu_op_t'(v[1][3:0]));
            check_tag(fu_data.trans_id, step_cnt[2:0]);
            check_operand(fu_data.operand_a, v[24], "operand_a");
            check_operand(fu_data.operand_b, v[25], "operand_b");
            check_operand(fu_data.imm, v[9], "imm");
        end
        drive_idle();
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        step_cnt = 0;
        drive_idle();
        rst_ni = 1'b0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_unit(fu_valid, '0);
        check_fu(fu_data.fu, issue_pkg::NONE);

        fd = $fopen("verification/issue_testdata.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the test data file");
        end
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() < 6 || line[0] == "#") begin
                continue;
            end
            step_cnt++;
            if (line.substr(0, 5) == "COMMIT") begin
                void'($sscanf(line.substr(7, line.len() - 1), "%h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5]));
                apply_commit();
            end else if (line.substr(0, 4) == "ISSUE") begin
                void'($sscanf(line.substr(6, line.len() - 1),
                              "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                              v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16],
                              v[17], v[18], v[19], v[20], v[21], v[22], v[23], v[24], v[25]));
                apply_issue();
            end else begin
                stop_run($sformatf("unknown line kind in test data: %s", line));
            end
        end
        $fclose(fd);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* verification/issue_assert.sv */
module issue_assert (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 flush_i,
    input logic                 issue_valid_i,
    input logic                 issue_ack_o,
    input issue_pkg::fu_data_t  fu_data_o,
    input issue_pkg::fu_valid_t fu_valid_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // only one unit started per cycle
    a_valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(fu_valid_o))
        else $error("more than one unit valid");

    // squashed instructions never reach execute
    a_flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> (fu_valid_o == '0))
        else $error("unit valid after flush");

    // branch unit compares its operands right away
    a_branch_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fu_valid_o.branch |-> !$isunknown({fu_data_o.operand_a, fu_data_o.operand_b}))
        else $error("unknown branch operand");

    a_ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_ack_o |-> issue_valid_i)
        else $error("ack without valid instruction");

endmodule

bind issue_ctrl issue_assert i_issue_assert (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid_i),
    .issue_ack_o   (issue_ack_o),
    .fu_data_o     (fu_data_o),
    .fu_valid_o    (fu_valid_o)
);

/* verilog/issue_read_operands.sv */
module issue_read_operands (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // issue port from the scoreboard
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_valid_i,
    output logic                    issue_ack_o,
    // scoreboard operand lookup
    output issue_pkg::reg_addr_t    rs1_o,
    output issue_pkg::reg_addr_t    rs2_o,
    input  issue_pkg::fwd_port_t    fwd_rs1_i,
    input  issue_pkg::fwd_port_t    fwd_rs2_i,
    input  issue_pkg::clobber_t     clobber_i,
    // commit write-back
    input  issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    // readiness from execute
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    // toward execute
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::fu_valid_t    fu_valid_o
);

    logic                fwd_rs1;
    logic                fwd_rs2;
    logic                stall;
    logic                waw_ok;
    issue_pkg::xlen_t    rdata_a;
    issue_pkg::xlen_t    rdata_b;
    issue_pkg::fu_data_t fu_data_next;

    // scoreboard polls the same sources we read
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // ------------------------------------------------------------------
    // register file, hazards, operand mux, issue control
    // ------------------------------------------------------------------
    int_regfile i_int_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    operand_hazard i_operand_hazard (
        .issue_instr_i (issue_instr_i),
        .clobber_i     (clobber_i),
        .fwd_rs1_i     (fwd_rs1_i),
        .fwd_rs2_i     (fwd_rs2_i),
        .commit_i      (commit_i),
        .fwd_rs1_o     (fwd_rs1),
        .fwd_rs2_o     (fwd_rs2),
        .stall_o       (stall),
        .waw_ok_o      (waw_ok)
    );

    operand_select i_operand_select (
        .issue_instr_i (issue_instr_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .fwd_rs1_i     (fwd_rs1_i),
        .fwd_rs2_i     (fwd_rs2_i),
        .fwd_rs1_en_i  (fwd_rs1),
        .fwd_rs2_en_i  (fwd_rs2),
        .fu_data_o     (fu_data_next)
    );

    issue_ctrl i_issue_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .issue_instr_i (issue_instr_i),
        .issue_valid_i (issue_valid_i),
        .issue_ack_o   (issue_ack_o),
        .stall_i       (stall),
        .waw_ok_i      (waw_ok),
        .flu_ready_i   (flu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .fu_data_i     (fu_data_next),
        .fu_data_o     (fu_data_o),
        .fu_valid_o    (fu_valid_o)
    );

endmodule

/* verilog/issue_ctrl.sv */
module issue_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // issue handshake
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_valid_i,
    output logic                    issue_ack_o,
    // hazard results
    input  logic                    stall_i,
    input  logic                    waw_ok_i,
    // readiness from execute
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    // ID/EX register
    input  issue_pkg::fu_data_t     fu_data_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::fu_valid_t    fu_valid_o
);

    logic                 fu_busy;
    logic                 issue_fire;
    issue_pkg::fu_valid_t fu_valid_d;
    issue_pkg::fu_valid_t fu_valid_q;
    issue_pkg::fu_data_t  fu_data_q;

    // ------------------------------------------------------------------
    // unit busy
    // ------------------------------------------------------------------
    // fixed latency units share one ready, load and store use the lsu
    always_comb begin
        unique case (issue_instr_i.fu)
            issue_pkg::ALU, issue_pkg::CTRL_FLOW, issue_pkg::MULT, issue_pkg::CSR:
                fu_busy = ~flu_ready_i;
            issue_pkg::LOAD, issue_pkg::STORE:
                fu_busy = ~lsu_ready_i;
            default:
                fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // issue acknowledge
    // ------------------------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            // operands ready, unit free and rd not claimed twice
            if (!stall_i && !fu_busy && waw_ok_i) begin
                issue_ack_o = 1'b1;
            end
            // excepting or unit-less instructions just pass through
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == issue_pkg::NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply in execute owns the fixed latency result bus next cycle
        if (fu_valid_q.mult && (issue_instr_i.fu != issue_pkg::MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    assign issue_fire = issue_valid_i & issue_ack_o;

    // next unit valid, at most one bit
    always_comb begin
        fu_valid_d = '0;
        if (issue_fire && !issue_instr_i.ex_valid) begin
            unique case (issue_instr_i.fu)
                issue_pkg::ALU:                      fu_valid_d.alu    = 1'b1;
                issue_pkg::CTRL_FLOW:                fu_valid_d.branch = 1'b1;
                issue_pkg::LOAD, issue_pkg::STORE:   fu_valid_d.lsu    = 1'b1;
                issue_pkg::MULT:                     fu_valid_d.mult   = 1'b1;
                issue_pkg::CSR:                      fu_valid_d.csr    = 1'b1;
                default:                             fu_valid_d        = '0;
            endcase
        end
        // never start a unit on a squashed instruction
        if (flush_i) begin
            fu_valid_d = '0;
        end
    end

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_valid_q <= '0;
        end else begin
            fu_valid_q <= fu_valid_d;
        end
    end

    // payload only moves on an accepted instruction
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_q <= '{fu: issue_pkg::NONE, operator: issue_pkg::ADD, default: '0};
        end else if (issue_fire) begin
            fu_data_q <= fu_data_i;
        end
    end

    assign fu_data_o  = fu_data_q;
    assign fu_valid_o = fu_valid_q;

endmodule

/* verilog/operand_select.sv */
module operand_select (
    input  issue_pkg::issue_instr_t issue_instr_i,
    // register file read data
    input  issue_pkg::xlen_t        rdata_a_i,
    input  issue_pkg::xlen_t        rdata_b_i,
    // scoreboard replies and their enables from the hazard check
    input  issue_pkg::fwd_port_t    fwd_rs1_i,
    input  issue_pkg::fwd_port_t    fwd_rs2_i,
    input  logic                    fwd_rs1_en_i,
    input  logic                    fwd_rs2_en_i,
    // payload for the ID/EX register
    output issue_pkg::fu_data_t     fu_data_o
);

    // pc and zimm widened to the operand width
    issue_pkg::xlen_t pc_sext;
    issue_pkg::xlen_t zimm_zext;
    logic             imm_to_b;

    assign pc_sext = {{(issue_pkg::XLEN - issue_pkg::VLEN){issue_instr_i.pc[issue_pkg::VLEN-1]}},
                      issue_instr_i.pc};
    assign zimm_zext = {{(issue_pkg::XLEN - issue_pkg::REG_ADDR_BITS){1'b0}}, issue_instr_i.rs1};

    // stores keep rs2 as data and branches compare rs2, imm travels separately
    assign imm_to_b = issue_instr_i.use_imm
                   && (issue_instr_i.fu != issue_pkg::STORE)
                   && (issue_instr_i.fu != issue_pkg::CTRL_FLOW);

    // ------------------------------------------------------------------
    // operand muxes
    // ------------------------------------------------------------------
    always_comb begin
        fu_data_o.fu       = issue_instr_i.fu;
        fu_data_o.operator = issue_instr_i.op;
        fu_data_o.trans_id = issue_instr_i.trans_id;
        // imm always carries the decoded immediate
        fu_data_o.imm      = issue_instr_i.result;

        // operand a, later choices override earlier ones
        fu_data_o.operand_a = fwd_rs1_en_i ? fwd_rs1_i.value : rdata_a_i;
        if (issue_instr_i.use_pc) begin
            fu_data_o.operand_a = pc_sext;
        end
        if (issue_instr_i.use_zimm) begin
            fu_data_o.operand_a = zimm_zext;
        end

        // operand b
        fu_data_o.operand_b = fwd_rs2_en_i ? fwd_rs2_i.value : rdata_b_i;
        if (imm_to_b) begin
            fu_data_o.operand_b = issue_instr_i.result;
        end
    end

endmodule

/* verilog/operand_hazard.sv */
module operand_hazard (
    input  issue_pkg::issue_instr_t issue_instr_i,
    // clobber list from the scoreboard
    input  issue_pkg::clobber_t     clobber_i,
    // forward replies for rs1 and rs2
    input  issue_pkg::fwd_port_t    fwd_rs1_i,
    input  issue_pkg::fwd_port_t    fwd_rs2_i,
    // commit writes of this cycle
    input  issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    // take the scoreboard value instead of the register file
    output logic                    fwd_rs1_o,
    output logic                    fwd_rs2_o,
    // an operand is not available yet
    output logic                    stall_o,
    // rd may be claimed by this instruction
    output logic                    waw_ok_o
);

    // units currently owning the source and destination registers
    issue_pkg::fu_t clob_rs1;
    issue_pkg::fu_t clob_rs2;
    issue_pkg::fu_t clob_rd;
    logic           rd_commit_hit;

    assign clob_rs1 = clobber_i[issue_instr_i.rs1];
    assign clob_rs2 = clobber_i[issue_instr_i.rs2];
    assign clob_rd  = clobber_i[issue_instr_i.rd];

    // ------------------------------------------------------------------
    // source operands
    // ------------------------------------------------------------------
    always_comb begin
        stall_o   = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;

        // rs1 holds the zimm field, nothing to wait for
        if (!issue_instr_i.use_zimm && (clob_rs1 != issue_pkg::NONE)) begin
            // CSR results only reach us through the register file
            if (fwd_rs1_i.valid && (clob_rs1 != issue_pkg::CSR)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end

        if (clob_rs2 != issue_pkg::NONE) begin
            if (fwd_rs2_i.valid && (clob_rs2 != issue_pkg::CSR)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // write after write on rd
    // ------------------------------------------------------------------
    // the older writer retires this cycle, so rd is free at the edge
    always_comb begin
        rd_commit_hit = 1'b0;
        for (int unsigned i = 0; i < issue_pkg::NR_COMMIT_PORTS; i++) begin
            if (commit_i[i].we && (commit_i[i].waddr == issue_instr_i.rd)) begin
                rd_commit_hit = 1'b1;
            end
        end
    end

    // no pending writer, or the pending one commits right now
    assign waw_ok_o = (clob_rd == issue_pkg::NONE) || rd_commit_hit;

endmodule

/* verilog/int_regfile.sv */
module int_regfile (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // two combinational read ports
    input  issue_pkg::reg_addr_t    raddr_a_i,
    input  issue_pkg::reg_addr_t    raddr_b_i,
    output issue_pkg::xlen_t        rdata_a_o,
    output issue_pkg::xlen_t        rdata_b_o,
    // write ports from commit
    input  issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i
);

    // register storage
    issue_pkg::xlen_t mem_q [issue_pkg::NR_REGS];

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    // ports are walked in order so the highest index wins a shared address
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 0; r < issue_pkg::NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            for (int unsigned i = 0; i < issue_pkg::NR_COMMIT_PORTS; i++) begin
                // x0 never takes a write
                if (commit_i[i].we && (commit_i[i].waddr != '0)) begin
                    mem_q[commit_i[i].waddr] <= commit_i[i].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    // x0 is forced to zero on the read path as well
    always_comb begin
        if (raddr_a_i == '0) begin
            rdata_a_o = '0;
        end else begin
            rdata_a_o = mem_q[raddr_a_i];
        end
    end

    always_comb begin
        if (raddr_b_i == '0) begin
            rdata_b_o = '0;
        end else begin
            rdata_b_o = mem_q[raddr_b_i];
        end
    end

endmodule

/* verilog/issue_pkg.sv */
package issue_pkg;

    // ------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------
    // integer register and operand width
    localparam int unsigned XLEN            = 64;
    // architectural integer registers
    localparam int unsigned NR_REGS         = 32;
    localparam int unsigned REG_ADDR_BITS   = $clog2(NR_REGS);
    // write-back ports from commit
    localparam int unsigned NR_COMMIT_PORTS = 2;
    // scoreboard tag width
    localparam int unsigned TRANS_ID_BITS   = 3;
    // virtual address width of the PC
    localparam int unsigned VLEN            = 39;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [VLEN-1:0]          vaddr_t;

    // ------------------------------------------------------------------
    // functional units and operators
    // ------------------------------------------------------------------
    // NONE must stay at zero, a cleared register reads as no unit
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ALU       = 3'd1,
        CTRL_FLOW = 3'd2,
        LOAD      = 3'd3,
        STORE     = 3'd4,
        MULT      = 3'd5,
        CSR       = 3'd6
    } fu_t;

    // reduced operator set, enough for the integer units
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL,
        BEQ, BNE, JALR,
        LD, SD,
        MUL,
        CSRRW
    } fu_op_t;

    // decoded instruction as handed over by the scoreboard
    typedef struct packed {
        vaddr_t    pc;
        trans_id_t trans_id;
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        // immediate, already sign-extended by decode
        xlen_t     result;
        logic      use_imm;
        logic      use_zimm;
        logic      use_pc;
        // instruction already carries an exception
        logic      ex_valid;
    } issue_instr_t;

    // per register, the unit that is going to write it
    typedef fu_t [NR_REGS-1:0] clobber_t;

    // one write-back port of the commit stage
    typedef struct packed {
        reg_addr_t waddr;
        xlen_t     wdata;
        logic      we;
    } commit_port_t;

    // scoreboard reply for one source operand
    typedef struct packed {
        xlen_t value;
        logic  valid;
    } fwd_port_t;

    // payload toward execute
    typedef struct packed {
        fu_t       fu;
        fu_op_t    operator;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // one valid per execute unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

endpackage
